/* src.f */
+incdir+hw
+incdir+bench
hw/simt_pkg.sv
hw/simt_alu.sv
hw/simt_exec_pipe.sv
hw/simt_exec_regs.sv
hw/simt_exec_top.sv
bench/tb_simt_exec.sv

/* run_sim.sh */
#!/bin/sh
# build and run the simt execution slice testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tb_simt_exec \
    -Mdir obj_dir -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "=== FAIL ===" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "simulator exited with status $run_status"
    exit 1
fi
exit 0

/* bench/tb_simt_exec_vectors.svh */
`ifndef TB_SIMT_EXEC_VECTORS_SVH
`define TB_SIMT_EXEC_VECTORS_SVH

// columns: name, kind, op, imm, imm_valid, active mask, row seed
typedef struct packed {
    instr_kind_e kind;
    alu_op_e     op;
    logic [15:0] imm;
    logic        imm_valid;
    logic [7:0]  mask;
    logic [15:0] seed;
} vec_t;

vec_t  vecs[$];
string vec_names[$];

// 32 bit lcg, numerical recipes constants
function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
endfunction

task automatic add_vec(input string name, input instr_kind_e kind, input alu_op_e op,
                       input logic [15:0] imm, input logic iv, input logic [7:0] mask,
                       input logic [15:0] seed);
    vecs.push_back('{kind: kind, op: op, imm: imm, imm_valid: iv, mask: mask, seed: seed});
    vec_names.push_back(name);
endtask

task automatic load_vectors();
    add_vec("add_reg",  WRITE, ADD, 16'h0000, 1'b0, 8'hFF, 16'h0011);
    add_vec("add_imm",  WRITE, ADD, 16'hFF80, 1'b1, 8'hFF, 16'h0022);
    add_vec("sub_reg",  WRITE, SUB, 16'h0000, 1'b0, 8'hFF, 16'h0033);
    add_vec("mul_lo16", WRITE, MUL, 16'h0000, 1'b0, 8'hFF, 16'h0044);
    add_vec("and_reg",  WRITE, AND, 16'h0000, 1'b0, 8'hFF, 16'h0055);
    add_vec("and_imm",  WRITE, AND, 16'h0F0F, 1'b1, 8'hFF, 16'h0066);
    add_vec("or_reg",   WRITE, OR,  16'h0000, 1'b0, 8'hFF, 16'h0077);
    add_vec("or_imm",   WRITE, OR,  16'h8001, 1'b1, 8'hFF, 16'h0088);
    add_vec("xor_reg",  WRITE, XOR, 16'h0000, 1'b0, 8'hFF, 16'h0099);
    add_vec("xor_imm",  WRITE, XOR, 16'h5A5A, 1'b1, 8'hFF, 16'h00AA);
    add_vec("shr_5",    WRITE, SHR, 16'h0280, 1'b0, 8'hFF, 16'h00BB);  // shamt 5
    add_vec("shl_31",   WRITE, SHL, 16'h0F80, 1'b0, 8'hFF, 16'h00CC);  // shamt 31
    add_vec("add_part", WRITE, ADD, 16'h0000, 1'b0, 8'hA5, 16'h00DD);
    add_vec("beq_full", BEQ,   ADD, 16'h1234, 1'b0, 8'hFF, 16'h0101);
    add_vec("beq_part", BEQ,   ADD, 16'hFFF0, 1'b0, 8'h3C, 16'h0202);
    add_vec("blt_full", BLT,   ADD, 16'h0400, 1'b0, 8'hFF, 16'h0303);
    add_vec("blt_part", BLT,   ADD, 16'h8000, 1'b0, 8'hC3, 16'h0404);
    add_vec("nop",      NOP,   ADD, 16'h0000, 1'b0, 8'hFF, 16'h0505);
endtask

`endif

/* bench/tb_simt_exec.sv */
`timescale 1ns/1ps
`default_nettype none

`include "simt_consts.svh"

module tb_simt_exec
    import simt_pkg::*;
();

    logic        clk;
    logic        rst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [3:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        issue_valid;
    issue_t      issue;
    logic        issue_ready;
    logic        out_valid;
    logic        out_ready;
    cdb_t        cdb;
    logic        cdb_write;
    branch_t     br;
    logic        br_valid;

    // one outstanding instruction in issue order
    typedef struct packed {
        logic [7:0]  vec;
        instr_kind_e kind;
        logic [7:0]  mask;
        logic [2:0]  warp;
        logic [4:0]  dst;
        logic [1:0]  scb;
        logic [31:0] instr;
        lane_data_t  data;
        logic [7:0]  outcome;
        logic [31:0] target;
        logic [31:0] issue_cyc;
    } exp_t;

    exp_t        exp_q[$];
    exp_t        head;
    logic [31:0] cyc = 32'd0;
    logic [7:0]  lane_en;
    logic        check_lat;
    int          n_issued;
    int          n_taken;
    logic        prev_stall = 1'b0;
    cdb_t        prev_cdb;
    branch_t     prev_br;
    logic [31:0] rd;
    logic        err;

    `include "tb_simt_exec_vectors.svh"

    simt_exec_top uut (
        .clk(clk), .rst_n(rst_n),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .issue_valid(issue_valid), .issue(issue), .issue_ready(issue_ready),
        .out_valid(out_valid), .out_ready(out_ready),
        .cdb(cdb), .cdb_write(cdb_write), .br(br), .br_valid(br_valid)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 32'd1;

    ////////////////////////////////////////////////////////////
    // failure reporting and checks
    ////////////////////////////////////////////////////////////
    task automatic stop_on_failure();
        $display("=== FAIL ===");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_timeout(input string what);
        $display("timeout while waiting for %s", what);
        stop_on_failure();
    endtask

    task automatic check(input string name, input logic [319:0] expected,
                         input logic [319:0] actual);
        if (expected !== actual) begin
            $display("Error %s expected %0h actual %0h", name, expected, actual);
            stop_on_failure();
        end
    endtask

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////
    function automatic logic [31:0] ref_lane(input alu_op_e op, input logic [31:0] a,
                                             input logic [31:0] b, input logic [15:0] imm,
                                             input logic iv);
        logic [31:0] ext;
        logic [31:0] opnd;
        logic [4:0]  sh;
        ext  = {{16{imm[15]}}, imm};
        opnd = (iv && (op == ADD || op == AND || op == OR || op == XOR)) ? ext : b;
        sh   = imm[11:7];
        case (op)
            ADD:     return a + opnd;
            SUB:     return a - b;
            MUL:     return {16'b0, a[15:0]} * {16'b0, b[15:0]};
            AND:     return a & opnd;
            OR:      return a | opnd;
            XOR:     return a ^ opnd;
            SHR:     return $signed(a) >>> sh;
            default: return a << sh;
        endcase
    endfunction

    function automatic issue_t build_issue(input logic [7:0] idx);
        issue_t      it;
        vec_t        v;
        logic [31:0] s;
        v = vecs[idx];
        it = '0;
        it.active_mask = v.mask;
        it.warp_id     = idx[2:0];
        it.instr       = {idx, 8'h5C, v.imm};
        it.kind        = v.kind;
        it.op          = v.op;
        it.imm         = v.imm;
        it.imm_valid   = v.imm_valid;
        it.dst         = idx[4:0] + 5'd1;
        it.scb_id      = idx[1:0];
        s = 32'h2bd6 ^ {v.seed, v.seed};
        for (int i = 0; i < `SIMT_LANES; i++) begin
            s = lcg_next(s);
            it.src1[i] = s;
            s = lcg_next(s);
            it.src2[i] = s;
            s = lcg_next(s);
            if (v.kind != WRITE && s[29]) it.src2[i] = it.src1[i];  // equal pairs for branches
        end
        return it;
    endfunction

    function automatic exp_t make_expected(input logic [7:0] idx, input issue_t it);
        exp_t e;
        logic taken;
        e = '0;
        e.vec  = idx;
        e.kind = it.kind;
        e.mask = it.active_mask & lane_en;
        e.warp = it.warp_id;
        e.dst  = it.dst;
        e.scb  = it.scb_id;
        e.instr     = it.instr;
        e.target    = {16'b0, it.imm};
        e.issue_cyc = cyc;
        for (int i = 0; i < `SIMT_LANES; i++) begin
            e.data[i] = ref_lane(it.op, it.src1[i], it.src2[i], it.imm, it.imm_valid);
            if (it.kind == BEQ) taken = (it.src1[i] == it.src2[i]);
            else taken = ($signed(it.src1[i]) < $signed(it.src2[i]));
            e.outcome[i] = taken && e.mask[i] && (it.kind == BEQ || it.kind == BLT);
        end
        return e;
    endfunction

    ////////////////////////////////////////////////////////////
    // bus tasks
    ////////////////////////////////////////////////////////////
    task automatic apb_access(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic perr);
        int n;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #1 penable = 1'b1;
        n = 0;
        @(negedge clk);
        while (!pready) begin
            n++;
            if (n > 20) report_timeout("apb pready");
            @(negedge clk);
        end
        rdata = prdata;
        perr  = pslverr;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic present_row(input logic [7:0] idx);
        issue_valid = 1'b1;
        issue       = build_issue(idx);
    endtask

    task automatic await_accept();
        int   n;
        logic done;
        exp_t e;
        n = 0;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            if (issue_ready) done = 1'b1;
            else begin
                n++;
                if (n > 100) report_timeout("issue_ready");
            end
            @(posedge clk);
            #1;
        end
        e = make_expected(issue.instr[31:24], issue);
        exp_q.push_back(e);
        n_issued++;
        if (e.outcome != 8'h00) n_taken++;
        issue_valid = 1'b0;
    endtask

    task automatic issue_row(input logic [7:0] idx);
        present_row(idx);
        await_accept();
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #1;
            n++;
            if (n > 200) report_timeout("pipeline drain");
        end
        repeat (2) @(posedge clk);  // counters trail the handshake
        #1;
    endtask

    ////////////////////////////////////////////////////////////
    // output monitor
    ////////////////////////////////////////////////////////////
    task automatic compare_output(input exp_t e);
        string nm;
        nm = vec_names[e.vec];
        if (e.kind == WRITE) begin
            check($sformatf("%s.cdb_write", nm), 1, cdb_write);
            check($sformatf("%s.br_valid", nm), 0, br_valid);
            check($sformatf("%s.data", nm), e.data, cdb.data);
            check($sformatf("%s.dst", nm), e.dst, cdb.dst);
            check($sformatf("%s.warp_id", nm), e.warp, cdb.warp_id);
            check($sformatf("%s.active_mask", nm), e.mask, cdb.active_mask);
            check($sformatf("%s.instr", nm), e.instr, cdb.instr);
        end else if (e.kind == NOP) begin
            check($sformatf("%s.cdb_write", nm), 0, cdb_write);
            check($sformatf("%s.br_valid", nm), 0, br_valid);
        end else begin
            check($sformatf("%s.br_valid", nm), 1, br_valid);
            check($sformatf("%s.cdb_write", nm), 0, cdb_write);
            check($sformatf("%s.outcome", nm), e.outcome, br.outcome);
            check($sformatf("%s.target", nm), e.target, br.target);
            check($sformatf("%s.br_warp", nm), e.warp, br.warp_id);
            check($sformatf("%s.scb_id", nm), e.scb, br.scb_id);
        end
        // handshake edge is the one after this negedge
        if (check_lat) check($sformatf("%s.latency", nm), 2, cyc + 32'd1 - e.issue_cyc);
    endtask

    always @(negedge clk) begin
        if (rst_n) begin
            if (prev_stall) begin
                check("stall.out_valid", 1, out_valid);
                check("stall.cdb", prev_cdb, cdb);
                check("stall.br", prev_br, br);
            end
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    $display("output handshake with no instruction outstanding");
                    stop_on_failure();
                end else begin
                    head = exp_q.pop_front();
                    compare_output(head);
                end
            end
            prev_stall = out_valid && !out_ready;
            prev_cdb   = cdb;
            prev_br    = br;
        end
    end

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////
    initial begin
        rst_n       = 1'b0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = 4'h0;
        pwdata      = 32'h0;
        issue_valid = 1'b0;
        issue       = '0;
        out_ready   = 1'b1;
        lane_en     = 8'hFF;
        check_lat   = 1'b0;
        n_issued    = 0;
        n_taken     = 0;
        load_vectors();

        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;

        // idle after reset with execution disabled
        repeat (4) begin
            @(negedge clk);
            check("reset.issue_ready", 0, issue_ready);
            check("reset.out_valid", 0, out_valid);
            check("reset.cdb_write", 0, cdb_write);
            check("reset.br_valid", 0, br_valid);
            check("reset.pslverr", 0, pslverr);
        end
        @(posedge clk);
        #1;
        apb_access(1'b0, `SIMT_REG_CTRL, 32'h0, rd, err);
        check("reset.ctrl", 32'h0000FF00, rd);

        // all lanes at full rate
        apb_access(1'b1, `SIMT_REG_CTRL, 32'h0000FF01, rd, err);
        check_lat = 1'b1;
        for (int i = 0; i < vecs.size(); i++) issue_row(8'(i));
        wait_drain();

        // low four lanes only
        apb_access(1'b1, `SIMT_REG_CTRL, 32'h00000F01, rd, err);
        lane_en = 8'h0F;
        for (int i = 0; i < vecs.size(); i++) issue_row(8'(i));
        wait_drain();

        // back-pressure with two in flight then a stall
        apb_access(1'b1, `SIMT_REG_CTRL, 32'h0000FF01, rd, err);
        lane_en   = 8'hFF;
        check_lat = 1'b0;
        out_ready = 1'b0;
        issue_row(8'd0);
        issue_row(8'd1);
        present_row(8'd13);
        repeat (4) begin
            @(negedge clk);
            check("stall.issue_ready", 0, issue_ready);
            check("stall.held_valid", 1, out_valid);
        end
        @(posedge clk);
        #1 out_ready = 1'b1;
        await_accept();
        wait_drain();

        // counters and decode errors
        apb_access(1'b0, `SIMT_REG_RETIRED, 32'h0, rd, err);
        check("count.retired", n_issued, rd);
        apb_access(1'b0, `SIMT_REG_TAKEN, 32'h0, rd, err);
        check("count.taken", n_taken, rd);
        apb_access(1'b0, 4'hC, 32'h0, rd, err);
        check("decode.read_err", 1, err);
        apb_access(1'b1, 4'hC, 32'h0, rd, err);
        check("decode.write_err", 1, err);
        apb_access(1'b0, `SIMT_REG_CTRL, 32'h0, rd, err);
        check("decode.ctrl_kept", 32'h0000FF01, rd);
        apb_access(1'b1, `SIMT_REG_RETIRED, 32'h0, rd, err);
        apb_access(1'b0, `SIMT_REG_RETIRED, 32'h0, rd, err);
        check("clear.retired", 0, rd);
        apb_access(1'b0, `SIMT_REG_TAKEN, 32'h0, rd, err);
        check("clear.taken", 0, rd);

        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

/* hw/simt_exec_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "simt_consts.svh"

module simt_exec_top
    import simt_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    // apb
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [3:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    // issue from operand collector
    input  logic        issue_valid,
    input  issue_t      issue,
    output logic        issue_ready,
    // results
    output logic        out_valid,
    input  logic        out_ready,
    output cdb_t        cdb,
    output logic        cdb_write,
    output branch_t     br,
    output logic        br_valid
);

    exec_cfg_t              cfg;
    logic                   retire_pulse;
    logic                   taken_pulse;
    issue_t                 alu_stage;
    logic                   alu_valid;
    lane_data_t             alu_data;
    logic [`SIMT_LANES-1:0] br_outcome;
    logic [31:0]            br_target;

    simt_exec_regs u_regs (
        .clk(clk), .rst_n(rst_n),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .cfg(cfg), .retire_pulse(retire_pulse), .taken_pulse(taken_pulse)
    );

    simt_exec_pipe u_pipe (
        .clk(clk), .rst_n(rst_n), .cfg(cfg),
        .issue_valid(issue_valid), .issue(issue), .issue_ready(issue_ready),
        .alu_stage(alu_stage), .alu_valid(alu_valid),
        .alu_data(alu_data), .br_outcome(br_outcome), .br_target(br_target),
        .out_valid(out_valid), .out_ready(out_ready),
        .cdb(cdb), .cdb_write(cdb_write), .br(br), .br_valid(br_valid),
        .retire_pulse(retire_pulse), .taken_pulse(taken_pulse)
    );

    simt_alu u_alu (
        .stage(alu_stage), .valid(alu_valid),
        .data(alu_data), .br_outcome(br_outcome), .br_target(br_target)
    );

endmodule

`default_nettype wire

/* hw/simt_exec_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "simt_consts.svh"

module simt_exec_regs
    import simt_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [3:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output exec_cfg_t   cfg,
    input  logic        retire_pulse,
    input  logic        taken_pulse
);

    logic        access;
    logic        addr_ok;
    logic        wr_ctrl;
    logic        wr_clear;
    logic [31:0] retired_cnt;
    logic [31:0] taken_cnt;

    assign access   = psel && penable;   // access phase
    assign addr_ok  = (paddr == `SIMT_REG_CTRL) || (paddr == `SIMT_REG_RETIRED)
                   || (paddr == `SIMT_REG_TAKEN);
    assign pready   = 1'b1;              // no wait states
    assign pslverr  = access && !addr_ok;
    assign wr_ctrl  = access && pwrite && (paddr == `SIMT_REG_CTRL);
    assign wr_clear = access && pwrite &&
                      ((paddr == `SIMT_REG_RETIRED) || (paddr == `SIMT_REG_TAKEN));

    always_comb begin
        prdata = 32'b0;
        if (access && !pwrite) begin
            case (paddr)
                `SIMT_REG_CTRL:    prdata = {16'b0, cfg.lane_enable, 7'b0, cfg.exec_enable};
                `SIMT_REG_RETIRED: prdata = retired_cnt;
                `SIMT_REG_TAKEN:   prdata = taken_cnt;
                default:           prdata = 32'b0;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // control register and counters
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg.exec_enable <= 1'b0;
            cfg.lane_enable <= '1;       // all lanes on
        end else if (wr_ctrl) begin
            cfg.exec_enable <= pwdata[0];
            cfg.lane_enable <= pwdata[15:8];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            retired_cnt <= 32'b0;
            taken_cnt   <= 32'b0;
        end else if (wr_clear) begin
            retired_cnt <= 32'b0;        // either offset clears both
            taken_cnt   <= 32'b0;
        end else begin
            if (retire_pulse && (retired_cnt != '1)) retired_cnt <= retired_cnt + 32'd1;
            if (taken_pulse && (taken_cnt != '1))    taken_cnt   <= taken_cnt + 32'd1;
        end
    end

    a_penable_needs_psel: assert property (@(posedge clk) disable iff (!rst_n)
        penable |-> psel)
        else $error("penable without psel");

endmodule

`default_nettype wire

/* hw/simt_exec_pipe.sv */
`timescale 1ns/1ps
`default_nettype none

`include "simt_consts.svh"

module simt_exec_pipe
    import simt_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  exec_cfg_t              cfg,
    input  logic                   issue_valid,
    input  issue_t                 issue,
    output logic                   issue_ready,
    output issue_t                 alu_stage,
    output logic                   alu_valid,
    input  lane_data_t             alu_data,
    input  logic [`SIMT_LANES-1:0] br_outcome,
    input  logic [31:0]            br_target,
    output logic                   out_valid,
    input  logic                   out_ready,
    output cdb_t                   cdb,
    output logic                   cdb_write,
    output branch_t                br,
    output logic                   br_valid,
    output logic                   retire_pulse,
    output logic                   taken_pulse
);

    logic        s1_valid;
    logic        s2_valid;
    issue_t      s1;
    issue_t      issue_masked;
    instr_kind_e s2_kind;
    cdb_t        s2_cdb;
    branch_t     s2_br;
    logic        s1_adv;
    logic        s2_adv;
    logic        issue_fire;
    logic        out_fire;

    ////////////////////////////////////////////////////////////
    // stall logic
    ////////////////////////////////////////////////////////////
    assign s2_adv      = !s2_valid || out_ready;
    assign s1_adv      = s2_adv || !s1_valid;
    assign issue_ready = cfg.exec_enable && s1_adv;
    assign issue_fire  = issue_valid && issue_ready;
    assign out_fire    = s2_valid && out_ready;

    always_comb begin
        issue_masked             = issue;
        issue_masked.active_mask = issue.active_mask & cfg.lane_enable;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            if (s1_adv) s1_valid <= issue_fire;
            if (s2_adv) s2_valid <= s1_valid;  // bubble if stage 1 empty
        end
    end

    always_ff @(posedge clk) begin
        if (issue_fire) s1 <= issue_masked;
        if (s2_adv && s1_valid) begin
            s2_kind <= s1.kind;
            s2_cdb  <= '{active_mask: s1.active_mask, warp_id: s1.warp_id,
                         instr: s1.instr, dst: s1.dst, data: alu_data};
            s2_br   <= '{warp_id: s1.warp_id, scb_id: s1.scb_id,
                         outcome: br_outcome, target: br_target};
        end
    end

    assign alu_stage = s1;
    assign alu_valid = s1_valid;

    assign out_valid = s2_valid;
    assign cdb       = s2_cdb;
    assign br        = s2_br;
    assign cdb_write = s2_valid && (s2_kind == WRITE);
    assign br_valid  = s2_valid && ((s2_kind == BEQ) || (s2_kind == BLT));

    // counter strobes, one cycle after the output handshake
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            retire_pulse <= 1'b0;
            taken_pulse  <= 1'b0;
        end else begin
            retire_pulse <= out_fire;
            taken_pulse  <= out_fire && br_valid && (|s2_br.outcome);
        end
    end

    a_hold_under_stall: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(cdb) && $stable(br)
                                    && $stable(cdb_write) && $stable(br_valid))
        else $error("output changed while stalled");

    a_write_xor_branch: assert property (@(posedge clk) disable iff (!rst_n)
        !(cdb_write && br_valid))
        else $error("cdb_write and br_valid both high");

endmodule

`default_nettype wire

/* hw/simt_alu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "simt_consts.svh"

module simt_alu
    import simt_pkg::*;
(
    input  issue_t                 stage,
    input  logic                   valid,
    output lane_data_t             data,
    output logic [`SIMT_LANES-1:0] br_outcome,
    output logic [31:0]            br_target
);

    logic [`SIMT_DW-1:0] imm_sext;
    logic [4:0]          shamt;
    logic                is_write;
    logic                is_beq;
    logic                is_blt;

    assign imm_sext = {{(`SIMT_DW-16){stage.imm[15]}}, stage.imm};
    assign shamt    = stage.imm[11:7];     // shift amount lives in the imm field
    assign is_write = valid && (stage.kind == WRITE);
    assign is_beq   = valid && (stage.kind == BEQ);
    assign is_blt   = valid && (stage.kind == BLT);

    // one target per instruction, not per lane
    assign br_target = (is_beq || is_blt) ? {16'b0, stage.imm} : 32'b0;

    ////////////////////////////////////////////////////////////
    // per lane datapath
    ////////////////////////////////////////////////////////////
    genvar i;
    generate
        for (i = 0; i < `SIMT_LANES; i = i + 1) begin : g_lane
            logic [`SIMT_DW-1:0] a;
            logic [`SIMT_DW-1:0] b;
            logic [`SIMT_DW-1:0] b_sel;
            logic [`SIMT_DW-1:0] lane_res;
            logic                eq;
            logic                lt;

            assign a     = stage.src1[i];
            assign b     = stage.src2[i];
            assign b_sel = stage.imm_valid ? imm_sext : b;  // imm form of add/logic ops

            always_comb begin
                lane_res = '0;
                case (stage.op)
                    ADD:     lane_res = a + b_sel;
                    SUB:     lane_res = a - b;
                    MUL:     lane_res = a[15:0] * b[15:0];  // this lane's own low halves
                    AND:     lane_res = a & b_sel;
                    OR:      lane_res = a | b_sel;
                    XOR:     lane_res = a ^ b_sel;
                    SHR:     lane_res = $signed(a) >>> shamt;
                    SHL:     lane_res = a << shamt;
                    default: lane_res = '0;
                endcase
            end

            assign eq = (a == b);
            assign lt = ($signed(a) < $signed(b));

            assign data[i] = is_write ? lane_res : '0;

            // inactive lanes never report taken
            assign br_outcome[i] = stage.active_mask[i] &&
                                   ((is_beq && eq) || (is_blt && lt));
        end
    endgenerate

endmodule

`default_nettype wire

/* hw/simt_pkg.sv */
`default_nettype none

`include "simt_consts.svh"

package simt_pkg;

    // alu opcodes, same encoding as the operand collector sends
    typedef enum logic [3:0] {
        ADD = 4'd0,     // also add-immediate
        SUB = 4'd1,
        MUL = 4'd2,     // low 16 x low 16
        AND = 4'd3,
        OR  = 4'd4,
        XOR = 4'd5,
        SHR = 4'd6,     // arithmetic
        SHL = 4'd7
    } alu_op_e;

    typedef enum logic [1:0] {
        WRITE = 2'd0,   // result to cdb
        BEQ   = 2'd1,
        BLT   = 2'd2,
        NOP   = 2'd3    // retires silently
    } instr_kind_e;

    typedef logic [`SIMT_LANES-1:0][`SIMT_DW-1:0] lane_data_t;

    // one warp instruction from the operand collector
    typedef struct packed {
        logic [`SIMT_LANES-1:0]  active_mask;
        logic [`SIMT_WARP_W-1:0] warp_id;
        logic [31:0]             instr;
        instr_kind_e             kind;
        alu_op_e                 op;
        lane_data_t              src1;
        lane_data_t              src2;
        logic [15:0]             imm;
        logic                    imm_valid;
        logic [4:0]              dst;
        logic [`SIMT_SCB_W-1:0]  scb_id;
    } issue_t;

    typedef struct packed {
        logic [`SIMT_LANES-1:0]  active_mask;
        logic [`SIMT_WARP_W-1:0] warp_id;
        logic [31:0]             instr;
        logic [4:0]              dst;
        lane_data_t              data;
    } cdb_t;

    // branch resolution, br_valid also clears the scoreboard entry
    typedef struct packed {
        logic [`SIMT_WARP_W-1:0] warp_id;
        logic [`SIMT_SCB_W-1:0]  scb_id;
        logic [`SIMT_LANES-1:0]  outcome;
        logic [31:0]             target;
    } branch_t;

    typedef struct packed {
        logic                   exec_enable;
        logic [`SIMT_LANES-1:0] lane_enable;
    } exec_cfg_t;

endpackage

`default_nettype wire

/* hw/simt_consts.svh */
`ifndef SIMT_CONSTS_SVH
`define SIMT_CONSTS_SVH

// lane geometry
`define SIMT_LANES      8
`define SIMT_DW         32

// id widths
`define SIMT_WARP_W     3
`define SIMT_SCB_W      2

////////////////////////////////////////////////////////////
// apb register map, byte offsets on a 4 bit paddr
////////////////////////////////////////////////////////////
`define SIMT_REG_CTRL     4'h0
`define SIMT_REG_RETIRED  4'h4
`define SIMT_REG_TAKEN    4'h8

`endif
